// File: src.f
hw/div_arith_pkg.sv
hw/div_stream_pkg.sv
hw/div_step_if.sv
hw/remainder_integer_signed.sv
hw/step_fifo.sv
hw/quotient_integer_signed.sv
hw/divider_integer_signed.sv
verification/divider_integer_signed_asserts.sv
verification/divider_integer_signed_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module divider_integer_signed_tb -f src.f -o divider_sim &&
./obj_dir/divider_sim || exit 1

// File: verification/divider_integer_signed_tb.sv
// Signed divider testbench

`timescale 1ns/1ps
`default_nettype none

module divider_integer_signed_tb;

    localparam int W              = div_arith_pkg::WORD_WIDTH;
    localparam int SEED           = 32'hcb0e9f59;
    localparam int RANDOM_TESTS   = 300;
    localparam int PRESSURE_TESTS = 100;
    localparam int TIMEOUT_CYCLES = 2000;

    localparam logic [W-1:0] MOST_NEGATIVE = {1'b1, {(W-1){1'b0}}};

    logic         clock        = 1'b0;
    logic         arst_n;
    logic         input_valid;
    logic         input_ready;
    logic [W-1:0] dividend;
    logic [W-1:0] divisor;
    logic         output_valid;
    logic         output_ready = 1'b1;
    logic [W-1:0] quotient;
    logic [W-1:0] remainder;
    logic         div_by_zero;

    // pending results, {dividend, divisor, div_by_zero, quotient, remainder}
    logic [4*W:0] expected_q [$];

    int   seed;
    // random stream for the output_ready gaps
    int   ready_seed;
    int   sent_count;
    int   checked_count;
    int   stall_cycles;
    logic back_pressure = 1'b0;

    divider_integer_signed divider_integer_signed_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .input_valid  (input_valid),
        .input_ready  (input_ready),
        .dividend     (dividend),
        .divisor      (divisor),
        .output_valid (output_valid),
        .output_ready (output_ready),
        .quotient     (quotient),
        .remainder    (remainder),
        .div_by_zero  (div_by_zero)
    );

    // 10 ns clock
    always #5 clock = ~clock;

    // truncating division, remainder follows the dividend sign
    // divide by zero counts every step as a success
    function automatic logic [2*W:0] reference_result(input logic [W-1:0] a,
                                                      input logic [W-1:0] b);
        int   sa;
        int   sb;
        int   q;
        int   r;
        logic dbz;
        sa = int'($signed(a));
        sb = int'($signed(b));
        if (sb == 0) begin
            q   = (sa < 0) ? 1 : -1;
            r   = sa;
            dbz = 1'b1;
        end else begin
            q   = sa / sb;
            r   = sa % sb;
            dbz = 1'b0;
        end
        // overflow just keeps the low word
        return {dbz, q[W-1:0], r[W-1:0]};
    endfunction

    task automatic check_value(input logic [W-1:0] actual, input logic [W-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL %0t: %s, got %0d expected %0d",
                     $time, what, $signed(actual), $signed(expected));
            $display("test failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timed out waiting for %s", what);
        $display("test failed");
        $fatal(1, "timeout");
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_operands(input logic [W-1:0] a, input logic [W-1:0] b);
        int waited;
        waited      = 0;
        dividend    = a;
        divisor     = b;
        input_valid = 1'b1;
        expected_q.push_back({a, b, reference_result(a, b)});
        sent_count++;
        while (!input_ready) begin
            @(negedge clock);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                fail_timeout("input_ready");
            end
        end
        @(negedge clock);
    endtask

    task automatic idle_cycles(input int n);
        input_valid = 1'b0;
        repeat (n) @(negedge clock);
    endtask

    // random gaps in output_ready only while back-pressure is on
    always @(negedge clock) begin
        if (back_pressure) begin
            output_ready = (($random(ready_seed) & 3) == 0);
        end else begin
            output_ready = 1'b1;
        end
    end

    // compare every result at its output handshake
    always @(posedge clock) begin
        logic [4*W:0] entry;
        string        ops;
        if (arst_n && output_valid && output_ready) begin
            if (expected_q.size() == 0) begin
                $display("a result came out with no operands pending");
                $display("test failed");
                $fatal(1, "unexpected result");
            end else begin
                entry = expected_q.pop_front();
                ops   = $sformatf("%0d / %0d", $signed(entry[4*W:3*W+1]),
                                  $signed(entry[3*W:2*W+1]));
                check_value(quotient, entry[2*W-1:W], {"quotient of ", ops});
                check_value(remainder, entry[W-1:0], {"remainder of ", ops});
                check_value(W'(div_by_zero), W'(entry[2*W]), {"div_by_zero of ", ops});
                checked_count++;
            end
        end
        // operands waiting while the result is held back
        if (arst_n && output_valid && !output_ready && input_valid && !input_ready) begin
            stall_cycles++;
        end
    end

    initial begin
        int           i;
        int           waited;
        logic [W-1:0] a;
        logic [W-1:0] b;
        seed          = SEED;
        ready_seed    = SEED + 1;
        sent_count    = 0;
        checked_count = 0;
        stall_cycles  = 0;
        arst_n        = 1'b1;
        input_valid   = 1'b0;
        dividend      = '0;
        divisor       = '0;

        // reset for 8 cycles, released on a falling edge
        #1 arst_n = 1'b0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;

        // all sign combinations
        send_operands(W'(22), W'(7));
        send_operands(W'(-22), W'(7));
        send_operands(W'(22), W'(-7));
        send_operands(W'(-22), W'(-7));
        send_operands(W'(7), W'(22));
        send_operands(W'(-7), W'(22));
        send_operands(W'(7), W'(-22));
        send_operands(W'(-7), W'(-22));
        idle_cycles(3);

        // divide by zero
        send_operands(W'(0), W'(0));
        send_operands(W'(22), W'(0));
        send_operands(W'(-22), W'(0));
        send_operands(MOST_NEGATIVE, W'(0));
        idle_cycles(3);

        // extremes, including the overflowing quotient
        send_operands(MOST_NEGATIVE, W'(1));
        send_operands(MOST_NEGATIVE, W'(-1));
        send_operands(MOST_NEGATIVE, MOST_NEGATIVE);
        send_operands(W'(127), W'(-1));

        // back to back divisions, output always ready
        for (i = 0; i < RANDOM_TESTS; i++) begin
            a = W'($random(seed));
            b = W'($random(seed));
            send_operands(a, b);
        end

        // gaps on both sides
        back_pressure <= 1'b1;
        for (i = 0; i < PRESSURE_TESTS; i++) begin
            a = W'($random(seed));
            b = W'($random(seed));
            send_operands(a, b);
            if (($random(seed) & 3) == 0) begin
                idle_cycles(1 + ($random(seed) & 3));
            end
        end
        input_valid = 1'b0;
        back_pressure <= 1'b0;

        // drain whatever is still in flight
        waited = 0;
        while (expected_q.size() != 0) begin
            @(negedge clock);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                fail_timeout("the remaining results");
            end
        end

        check_value(W'(stall_cycles > 0), W'(1), "input_ready stall under back-pressure");

        if (checked_count == sent_count) begin
            $display("test passed");
            $finish;
        end else begin
            $display("only %0d of %0d results were checked", checked_count, sent_count);
            $display("test failed");
            $fatal(1, "results missing");
        end
    end

endmodule

`default_nettype wire

// File: verification/divider_integer_signed_asserts.sv
// Divider handshake assertions

`timescale 1ns/1ps
`default_nettype none

module divider_integer_signed_asserts (
    input wire logic                                 clock,
    input wire logic                                 arst_n,
    input wire logic                                 input_valid,
    input wire logic                                 input_ready,
    input wire logic                                 output_valid,
    input wire logic                                 output_ready,
    input wire logic [div_arith_pkg::WORD_WIDTH-1:0] quotient,
    input wire logic [div_arith_pkg::WORD_WIDTH-1:0] remainder,
    input wire logic                                 div_by_zero
);

    // a held result keeps valid and data until it is read
    property result_held;
        @(posedge clock) disable iff (!arst_n)
        output_valid && !output_ready |=> output_valid && $stable(quotient)
                                          && $stable(remainder) && $stable(div_by_zero);
    endproperty

    assert property (result_held)
        else $error("result changed before output_ready");

    // both handshakes quiet in reset
    assert property (@(posedge clock) !arst_n |-> !input_ready && !output_valid)
        else $error("handshake active during reset");

    // flag only rides on a valid result
    assert property (@(posedge clock) disable iff (!arst_n) div_by_zero |-> output_valid)
        else $error("div_by_zero without output_valid");

    // remainder unit is busy right after taking operands
    assert property (@(posedge clock) disable iff (!arst_n)
                     input_valid && input_ready |=> !input_ready)
        else $error("input_ready stayed high after acceptance");

endmodule

bind divider_integer_signed divider_integer_signed_asserts asserts_i (
    .clock        (clock),
    .arst_n       (arst_n),
    .input_valid  (input_valid),
    .input_ready  (input_ready),
    .output_valid (output_valid),
    .output_ready (output_ready),
    .quotient     (quotient),
    .remainder    (remainder),
    .div_by_zero  (div_by_zero)
);

`default_nettype wire

// File: hw/divider_integer_signed.sv
// Signed integer divider

`timescale 1ns/1ps
`default_nettype none

module divider_integer_signed (
    input  logic                                 clock,
    input  logic                                 arst_n,

    // operand side
    input  logic                                 input_valid,
    output logic                                 input_ready,
    input  logic [div_arith_pkg::WORD_WIDTH-1:0] dividend,
    input  logic [div_arith_pkg::WORD_WIDTH-1:0] divisor,

    // result side
    output logic                                 output_valid,
    input  logic                                 output_ready,
    output logic [div_arith_pkg::WORD_WIDTH-1:0] quotient,
    output logic [div_arith_pkg::WORD_WIDTH-1:0] remainder,
    output logic                                 div_by_zero
);

    // remainder unit into the FIFO
    div_step_if producer_steps (.clock(clock));
    // FIFO into the quotient unit
    div_step_if consumer_steps (.clock(clock));

    // trial subtractions, one outcome per cycle
    remainder_integer_signed remainder_i (
        .clock       (clock),
        .arst_n      (arst_n),
        .input_valid (input_valid),
        .input_ready (input_ready),
        .dividend    (dividend),
        .divisor     (divisor),
        .steps       (producer_steps)
    );

    // lets the next division start while the last one drains
    step_fifo step_fifo_i (
        .clock  (clock),
        .arst_n (arst_n),
        .push   (producer_steps),
        .pop    (consumer_steps)
    );

    // quotient build and result hold
    quotient_integer_signed quotient_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .steps        (consumer_steps),
        .output_valid (output_valid),
        .output_ready (output_ready),
        .quotient     (quotient),
        .remainder    (remainder),
        .div_by_zero  (div_by_zero)
    );

endmodule

`default_nettype wire

// File: hw/quotient_integer_signed.sv
// Signed quotient unit

`timescale 1ns/1ps
`default_nettype none

module quotient_integer_signed (
    input  logic                                 clock,
    input  logic                                 arst_n,
    div_step_if.sink                             steps,
    output logic                                 output_valid,
    input  logic                                 output_ready,
    output logic [div_arith_pkg::WORD_WIDTH-1:0] quotient,
    output logic [div_arith_pkg::WORD_WIDTH-1:0] remainder,
    output logic                                 div_by_zero
);

    logic [div_arith_pkg::STATE_WIDTH-1:0] state;
    logic [div_arith_pkg::STATE_WIDTH-1:0] state_next;

    // long quotient and the halving increment
    logic [div_arith_pkg::WORD_WIDTH_LONG-1:0] quotient_long;
    logic [div_arith_pkg::WORD_WIDTH_LONG-1:0] quotient_next;
    logic [div_arith_pkg::WORD_WIDTH_LONG-1:0] quotient_base;
    logic [div_arith_pkg::WORD_WIDTH_LONG-1:0] increment;
    logic [div_arith_pkg::WORD_WIDTH_LONG-1:0] increment_now;

    // result fields held until read
    logic [div_arith_pkg::WORD_WIDTH-1:0] remainder_held;
    logic                                 div_by_zero_held;

    logic step_taken;
    logic result_read;
    logic first_step;

    // steps are refused while a result waits, which backs up the FIFO
    assign output_valid = (state == div_arith_pkg::STATE_DONE);
    assign steps.ready  = ~output_valid;

    assign step_taken  = steps.valid && steps.ready;
    assign result_read = output_valid && output_ready;
    assign first_step  = (state == div_arith_pkg::STATE_LOAD);

    // first entry of a division starts from a cleared quotient
    assign quotient_base = first_step ? '0 : quotient_long;
    assign increment_now = first_step ? div_arith_pkg::INCREMENT_START : increment;

    // add when signs agree, subtract when they differ
    always_comb begin
        quotient_next = quotient_base;
        if (steps.step_ok) begin
            if (steps.quotient_negative) begin
                quotient_next = quotient_base - increment_now;
            end else begin
                quotient_next = quotient_base + increment_now;
            end
        end
    end

    // LOAD on the first entry, DONE on the last, back to LOAD when read
    always_comb begin
        state_next = state;
        if (step_taken && steps.last) begin
            state_next = div_arith_pkg::STATE_DONE;
        end else if (step_taken && first_step) begin
            state_next = div_arith_pkg::STATE_CALC;
        end
        if (result_read) begin
            state_next = div_arith_pkg::STATE_LOAD;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= div_arith_pkg::STATE_LOAD;
        end else begin
            state <= state_next;
        end
    end

    // quotient accumulation and result capture
    always_ff @(posedge clock) begin
        if (step_taken) begin
            quotient_long <= quotient_next;
            // next step weighs half as much
            increment     <= increment_now >> 1;
            if (steps.last) begin
                remainder_held   <= steps.remainder;
                div_by_zero_held <= steps.div_by_zero;
            end
        end
    end

    // overflowing quotients simply lose the top bit
    assign quotient    = quotient_long[div_arith_pkg::WORD_WIDTH-1:0];
    assign remainder   = remainder_held;
    assign div_by_zero = div_by_zero_held && output_valid;

endmodule

`default_nettype wire

// File: hw/step_fifo.sv
// Step outcome FIFO

`timescale 1ns/1ps
`default_nettype none

module step_fifo (
    input  logic       clock,
    input  logic       arst_n,
    div_step_if.sink   push,
    div_step_if.source pop
);

    // one entry is step_ok, quotient_negative, last, remainder, div_by_zero
    logic [div_arith_pkg::WORD_WIDTH+3:0] entry_mem [div_stream_pkg::STEP_FIFO_DEPTH];

    logic [div_stream_pkg::STEP_PTR_WIDTH-1:0] wr_ptr;
    logic [div_stream_pkg::STEP_PTR_WIDTH-1:0] rd_ptr;
    // one bit wider than the pointers to tell full from empty
    logic [div_stream_pkg::STEP_PTR_WIDTH:0]   count;

    logic full;
    logic empty;
    logic do_push;
    logic do_pop;

    // status from the occupancy count
    assign full  = (count == div_stream_pkg::STEP_FIFO_FULL);
    assign empty = (count == '0);

    // when full a write is still taken in the cycle an entry leaves
    assign push.ready = !full || pop.ready;
    assign pop.valid  = !empty;

    assign do_push = push.valid && push.ready;
    assign do_pop  = pop.valid && pop.ready;

    // entry storage
    always_ff @(posedge clock) begin
        if (do_push) begin
            entry_mem[wr_ptr] <= {push.step_ok, push.quotient_negative, push.last,
                                  push.remainder, push.div_by_zero};
        end
    end

    // head entry straight from storage
    assign {pop.step_ok, pop.quotient_negative, pop.last,
            pop.remainder, pop.div_by_zero} = entry_mem[rd_ptr];

    // pointers wrap at the buffer depth
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == div_stream_pkg::STEP_PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == div_stream_pkg::STEP_PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leave the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (!do_push && do_pop) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/remainder_integer_signed.sv
// Signed remainder unit

`timescale 1ns/1ps
`default_nettype none

module remainder_integer_signed (
    input  logic                                 clock,
    input  logic                                 arst_n,
    input  logic                                 input_valid,
    output logic                                 input_ready,
    input  logic [div_arith_pkg::WORD_WIDTH-1:0] dividend,
    input  logic [div_arith_pkg::WORD_WIDTH-1:0] divisor,
    div_step_if.source                           steps
);

    // control state
    logic                                       busy;
    logic [div_arith_pkg::STEP_COUNT_WIDTH-1:0] step_count;
    // low through reset, set on the first clock after release
    logic                                       reset_done;

    // running remainder, long so that -2**(N-1) keeps its magnitude
    logic signed [div_arith_pkg::WORD_WIDTH_LONG-1:0] remainder_long;
    // divisor, starts WORD_WIDTH places left and walks right
    logic signed [div_arith_pkg::SHIFT_WIDTH-1:0]     divisor_shift;

    // operand facts captured at load
    logic dividend_negative;
    logic signs_differ;
    logic divisor_zero;

    // datapath
    logic signed [div_arith_pkg::SHIFT_WIDTH-1:0] divisor_wide;
    logic signed [div_arith_pkg::SHIFT_WIDTH-1:0] remainder_wide;
    logic signed [div_arith_pkg::SHIFT_WIDTH-1:0] trial;
    logic                                         trial_ok;

    // events
    logic load_operands;
    logic step_taken;
    logic last_step;

    // only take new operands between divisions, never before the first clock after reset
    assign input_ready   = ~busy && reset_done;
    assign load_operands = input_valid && input_ready;
    assign step_taken    = steps.valid && steps.ready;
    assign last_step     = (step_count == '0);

    // sign extension happens in the signed assignments
    assign divisor_wide   = $signed(divisor);
    assign remainder_wide = remainder_long;

    // move the remainder toward zero by the shifted divisor
    // same signs subtract, differing signs add
    assign trial = signs_differ ? (remainder_wide + divisor_shift)
                                : (remainder_wide - divisor_shift);

    // the divisor fit if the result is zero or kept the dividend's sign
    // a zero divisor fits every time, giving the all-ones quotient
    assign trial_ok = divisor_zero
                   || (trial == '0)
                   || (trial[div_arith_pkg::SHIFT_WIDTH-1] == dividend_negative);

    // input side opens one clock after reset is released
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            reset_done <= 1'b0;
        end else begin
            reset_done <= 1'b1;
        end
    end

    // step counter and busy flag
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy       <= 1'b0;
            step_count <= '0;
        end else if (load_operands) begin
            busy       <= 1'b1;
            step_count <= div_arith_pkg::STEP_COUNT_START;
        end else if (step_taken) begin
            // idle again the cycle after the last entry leaves
            busy <= ~last_step;
            if (!last_step) begin
                step_count <= step_count - 1'b1;
            end
        end
    end

    // operand and remainder registers
    always_ff @(posedge clock) begin
        if (load_operands) begin
            remainder_long    <= $signed(dividend);
            divisor_shift     <= divisor_wide <<< div_arith_pkg::WORD_WIDTH;
            dividend_negative <= dividend[div_arith_pkg::WORD_WIDTH-1];
            signs_differ      <= dividend[div_arith_pkg::WORD_WIDTH-1]
                               ^ divisor[div_arith_pkg::WORD_WIDTH-1];
            divisor_zero      <= (divisor == '0);
        end else if (step_taken) begin
            // keep the trial result only when the divisor fit
            if (trial_ok) begin
                remainder_long <= trial[div_arith_pkg::WORD_WIDTH_LONG-1:0];
            end
            // arithmetic shift keeps the divisor sign
            divisor_shift <= divisor_shift >>> 1;
        end
    end

    // one step outcome offered per cycle while busy
    assign steps.valid             = busy;
    assign steps.step_ok           = trial_ok;
    assign steps.quotient_negative = signs_differ;
    assign steps.last              = last_step;

    // remainder after this step, truncated back to the word
    assign steps.remainder = trial_ok ? trial[div_arith_pkg::WORD_WIDTH-1:0]
                                      : remainder_long[div_arith_pkg::WORD_WIDTH-1:0];

    // flag only rides on the last entry
    assign steps.div_by_zero = divisor_zero && last_step;

endmodule

`default_nettype wire

// File: hw/div_step_if.sv
// Division step stream

`timescale 1ns/1ps
`default_nettype none

interface div_step_if (
    input logic clock
);

    // handshake, an entry moves when both are high at a rising clock
    logic valid;
    logic ready;

    // trial subtraction succeeded
    logic step_ok;
    // operand signs differ
    logic quotient_negative;
    // final step of a division
    logic last;

    // only meaningful together with last
    logic [div_arith_pkg::WORD_WIDTH-1:0] remainder;
    logic                                 div_by_zero;

    // producer side
    modport source (
        input  clock,
        output valid,
        output step_ok,
        output quotient_negative,
        output last,
        output remainder,
        output div_by_zero,
        input  ready
    );

    // consumer side
    modport sink (
        input  clock,
        input  valid,
        input  step_ok,
        input  quotient_negative,
        input  last,
        input  remainder,
        input  div_by_zero,
        output ready
    );

endinterface

`default_nettype wire

// File: hw/div_stream_pkg.sv
// Step stream buffer constants

`default_nettype none

package div_stream_pkg;

    // entries held between the remainder and quotient units
    localparam int STEP_FIFO_DEPTH = 4;
    localparam int STEP_PTR_WIDTH  = $clog2(STEP_FIFO_DEPTH);

    // pointer value before wrapping back to zero
    localparam logic [STEP_PTR_WIDTH-1:0] STEP_PTR_LAST = STEP_PTR_WIDTH'(STEP_FIFO_DEPTH - 1);

    // occupancy when every entry is taken
    localparam logic [STEP_PTR_WIDTH:0] STEP_FIFO_FULL = (STEP_PTR_WIDTH + 1)'(STEP_FIFO_DEPTH);

endpackage

`default_nettype wire

// File: hw/div_arith_pkg.sv
// Divider arithmetic constants

`default_nettype none

package div_arith_pkg;

    // operand and result width
    localparam int WORD_WIDTH = 8;

    // one extra bit so the most negative operand still has a magnitude
    localparam int WORD_WIDTH_LONG = WORD_WIDTH + 1;

    // holds the long divisor moved left by up to WORD_WIDTH places
    localparam int SHIFT_WIDTH = WORD_WIDTH_LONG + WORD_WIDTH;

    // one trial subtraction per bit of the long quotient
    localparam int STEP_COUNT       = WORD_WIDTH_LONG;
    localparam int STEP_COUNT_WIDTH = $clog2(STEP_COUNT);

    // down-counter start, reaches zero on the last step
    localparam logic [STEP_COUNT_WIDTH-1:0] STEP_COUNT_START = STEP_COUNT_WIDTH'(STEP_COUNT - 1);

    // quotient increment for the first step, top bit of the long word
    localparam logic [WORD_WIDTH_LONG-1:0] INCREMENT_START = {1'b1, {WORD_WIDTH{1'b0}}};

    // quotient unit FSM, LOAD -> CALC -> DONE -> LOAD
    localparam int                     STATE_WIDTH = 2;
    localparam logic [STATE_WIDTH-1:0] STATE_LOAD  = 2'b00;
    localparam logic [STATE_WIDTH-1:0] STATE_CALC  = 2'b10;
    localparam logic [STATE_WIDTH-1:0] STATE_DONE  = 2'b11;

endpackage

`default_nettype wire
